// ==== testbench/dma_tests.txt ====
// columns: kind did addr data, all hex. kinds: 1 write, 2 read data words,
// 3 one read that must get no response, 4 idle data cycles (did 1 = bus quiet), 0 end.
4 1 000000 14                // after reset, nothing fetched.
3 3 000010 0
1 3 000010 1000              // start.
1 3 000011 5                 // length in words.
1 3 000013 1                 // trigger.
2 3 000010 5
3 3 000010 0                 // burst drained.
4 1 000000 a
1 3 000010 20000
1 3 000011 28                // longer than the fifo.
1 3 000013 1
4 0 000000 32                // let the fifo fill.
3 4 000010 0                 // other device id.
3 3 000110 0                 // other prefix.
1 4 000010 8000
1 3 000020 8000
1 3 000010 3000              // next burst, written mid run.
1 3 000011 6
1 3 000013 1
2 3 000010 2e                // 40 old words then 6 new ones.
3 3 000010 0
1 3 000010 7ff8
1 3 000011 3
1 3 000012 1                 // autotrigger.
2 3 000010 b                 // wraps to the start.
0 0 000000 0

// ==== sim.f ====
logic/fsab_pkg.sv
logic/spam_pkg.sv
logic/dma_fetch_engine.sv
logic/dma_read_fifo.sv
logic/dma_spam_port.sv
logic/dma_read_controller.sv
testbench/tb_clock_gen.sv
testbench/tb_fsab_memory.sv
testbench/tb_dma_read_controller.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_dma_read_controller -f sim.f -o sim_dma

run: compile
	@out="$$(./obj_dir/sim_dma)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== testbench/tb_dma_read_controller.sv ====
`timescale 1ns/10ps

module tb_dma_read_controller;
	import fsab_pkg::*;
	import spam_pkg::*;

	logic                   clk;
	logic                   rst_b;
	logic                   fsabo_valid;
	fsab_req_e              fsabo_mode;
	logic [fsab_did_w-1:0]  fsabo_did;
	logic [fsab_did_w-1:0]  fsabo_subdid;
	logic [fsab_addr_w-1:0] fsabo_addr;
	logic [fsab_len_w-1:0]  fsabo_len;
	logic [fsab_data_w-1:0] fsabo_data;
	logic [fsab_mask_w-1:0] fsabo_mask;
	logic                   fsabo_credit;
	logic                   fsabi_valid;
	logic [fsab_did_w-1:0]  fsabi_did;
	logic [fsab_did_w-1:0]  fsabi_subdid;
	logic [fsab_data_w-1:0] fsabi_data;
	logic                   spamo_valid;
	logic                   spamo_r_nw;
	logic [spam_did_w-1:0]  spamo_did;
	logic [spam_addr_w-1:0] spamo_addr;
	logic [spam_data_w-1:0] spamo_data;
	logic                   spami_busy_b;
	logic [spam_data_w-1:0] spami_data;
	int                     credit_errors;

	logic [63:0]            tests [256]; // four fields per test line.
	logic [fsab_addr_w-1:0] exp_q [$];   // addresses still to come back.
	logic [fsab_addr_w-1:0] m_start;
	logic [fsab_addr_w-1:0] m_len;
	logic                   m_auto;
	int                     errors;
	int                     n_lines = 0;

	tb_clock_gen u_clk (.*);
	tb_fsab_memory u_mem (.*);
	dma_read_controller uut (.*);

	// address in the high half, inverted address in the low half.
	function automatic logic [63:0] mem_word(input logic [fsab_addr_w-1:0] a);
		return {{1'b0, a}, ~{1'b0, a}};
	endfunction

	task automatic queue_burst();
		for (int k = 0; k < int'(m_len); k++) begin
			exp_q.push_back(m_start + fsab_addr_w'(8 * k));
		end
	endtask

	task automatic spam_write(input logic [3:0] did, input logic [23:0] addr,
		input logic [63:0] data);
		@(negedge clk);
		spamo_valid = 1'b1;
		spamo_r_nw  = 1'b0;
		spamo_did   = did;
		spamo_addr  = addr;
		spamo_data  = data;
		@(negedge clk);
		spamo_valid = 1'b0;
		if ((did == dma_spam_did) && (addr[23:2] == dma_spam_prefix[23:2])) begin
			case (addr[1:0])
				2'd0: m_start = {data[fsab_addr_w-1:3], 3'b000};
				2'd1: m_len = data[fsab_addr_w-1:0];
				2'd2: m_auto = data[0];
				default: begin
					if (data[0]) begin
						queue_burst();
					end
				end
			endcase
		end
	endtask

	// holds the read strobe until n words came back.
	task automatic read_words(input int n);
		int got;
		logic [fsab_addr_w-1:0] a;
		got = 0;
		@(negedge clk);
		spamo_valid = 1'b1;
		spamo_r_nw  = 1'b1;
		spamo_did   = dma_spam_did;
		spamo_addr  = dma_spam_prefix;
		while (got < n) begin
			@(negedge clk);
			if (spami_busy_b) begin
				got++;
				if (got == n) begin
					spamo_valid = 1'b0;
				end
				if ((exp_q.size() == 0) && m_auto && (m_len != '0)) begin
					queue_burst(); // autotrigger wraps to the start.
				end
				if (exp_q.size() == 0) begin
					$display("word %h read back when none was expected", spami_data);
					errors++;
				end else begin
					a = exp_q.pop_front();
					if (spami_data !== mem_word(a)) begin
						$display("[ERROR] spami_data: got %h expected %h", spami_data, mem_word(a));
						errors++;
					end
				end
			end
		end
	endtask

	task automatic read_no_response(input logic [3:0] did, input logic [23:0] addr);
		@(negedge clk);
		spamo_valid = 1'b1;
		spamo_r_nw  = 1'b1;
		spamo_did   = did;
		spamo_addr  = addr;
		@(negedge clk);
		spamo_valid = 1'b0;
		if (spami_busy_b !== 1'b0) begin
			$display("[ERROR] spami_busy_b: got %h expected 0", spami_busy_b);
			errors++;
		end
	endtask

	task automatic idle_cycles(input int n, input logic quiet);
		repeat (n) begin
			@(negedge clk);
			if (quiet && (fsabo_valid !== 1'b0)) begin
				$display("[ERROR] fsabo_valid: got %h expected 0", fsabo_valid);
				errors++;
			end
			if (quiet && (spami_busy_b !== 1'b0)) begin
				$display("[ERROR] spami_busy_b: got %h expected 0", spami_busy_b);
				errors++;
			end
		end
	endtask

	// every request is a one word read carrying the controller's ids.
	always @(negedge clk) begin
		if (fsabo_valid === 1'b1) begin
			if (fsabo_mode !== fsab_read) begin
				$display("[ERROR] fsabo_mode: got %h expected %h", fsabo_mode, fsab_read);
				errors++;
			end
			if (fsabo_did !== dma_fsab_did) begin
				$display("[ERROR] fsabo_did: got %h expected %h", fsabo_did, dma_fsab_did);
				errors++;
			end
			if (fsabo_subdid !== dma_fsab_subdid) begin
				$display("[ERROR] fsabo_subdid: got %h expected %h", fsabo_subdid,
					dma_fsab_subdid);
				errors++;
			end
			if (fsabo_len !== fsab_len_w'(1)) begin
				$display("[ERROR] fsabo_len: got %h expected 1", fsabo_len);
				errors++;
			end
			if ($isunknown(fsabo_data) || $isunknown(fsabo_mask)) begin
				$display("read of %h carries undriven data or mask bits", fsabo_addr);
				errors++;
			end
		end
	end

	initial begin
		int i;
		logic [63:0] op;
		errors      = 0;
		m_start     = '0;
		m_len       = '0;
		m_auto      = 1'b0;
		spamo_valid = 1'b0;
		spamo_r_nw  = 1'b0;
		spamo_did   = '0;
		spamo_addr  = '0;
		spamo_data  = '0;
		for (i = 0; i < 256; i++) begin
			tests[i] = '0;
		end
		$readmemh("testbench/dma_tests.txt", tests);
		i = 0;
		while (tests[4 * i] != '0) begin
			i++;
		end
		n_lines = i;
		wait (rst_b === 1'b1);
		for (i = 0; i < n_lines; i++) begin
			op = tests[4 * i];
			case (op)
				64'd1: spam_write(tests[4 * i + 1][3:0], tests[4 * i + 2][23:0], tests[4 * i + 3]);
				64'd2: read_words(int'(tests[4 * i + 3]));
				64'd3: read_no_response(tests[4 * i + 1][3:0], tests[4 * i + 2][23:0]);
				64'd4: idle_cycles(int'(tests[4 * i + 3]), tests[4 * i + 1][0]);
				default: begin
					$display("unknown test kind %0h on test line %0d", op, i);
					errors++;
				end
			endcase
		end
		repeat (2) @(negedge clk);
		$display("errors: %0d in checks, %0d in the memory model", errors, credit_errors);
		if ((errors == 0) && (credit_errors == 0)) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// watchdog, 200 cycles for each test line.
	initial begin
		wait (n_lines > 0);
		repeat (n_lines * 200 + 20) @(posedge clk);
		$display("timeout: the tests did not finish in %0d cycles", n_lines * 200);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== testbench/tb_fsab_memory.sv ====
`timescale 1ns/10ps

module tb_fsab_memory (
	input  logic                             clk,
	input  logic                             fsabo_valid,
	input  logic [fsab_pkg::fsab_addr_w-1:0] fsabo_addr,
	output logic                             fsabo_credit,
	output logic                             fsabi_valid,
	output logic [fsab_pkg::fsab_did_w-1:0]  fsabi_did,
	output logic [fsab_pkg::fsab_did_w-1:0]  fsabi_subdid,
	output logic [fsab_pkg::fsab_data_w-1:0] fsabi_data,
	output int                               credit_errors
);
	import fsab_pkg::*;

	logic [fsab_addr_w-1:0] addr_q [$]; // requests waiting for their answer.
	int                     due_q [$];
	int                     cycle;
	int                     credits;
	int                     last_due;
	int                     due;

	initial begin
		fsabo_credit  = 1'b0;
		fsabi_valid   = 1'b0;
		fsabi_did     = '0;
		fsabi_subdid  = '0;
		fsabi_data    = '0;
		credit_errors = 0;
		cycle         = 0;
		credits       = fsab_credits;
		last_due      = 0;
		void'($urandom(32'hb11b));
		forever begin
			@(negedge clk);
			cycle++;
			fsabi_valid  = 1'b0;
			fsabo_credit = 1'b0;
			// request held for the coming edge.
			if (fsabo_valid === 1'b1) begin
				if (credits == 0) begin
					$display("read of %h issued with no credit held", fsabo_addr);
					credit_errors++;
				end else begin
					credits--;
				end
				due = cycle + $urandom_range(1, 6);
				if (due <= last_due) begin
					due = last_due + 1; // keep answers in order.
				end
				last_due = due;
				addr_q.push_back(fsabo_addr);
				due_q.push_back(due);
			end
			if ((due_q.size() > 0) && (due_q[0] <= cycle)) begin
				fsabi_valid  = 1'b1;
				fsabi_did    = dma_fsab_did;
				fsabi_subdid = dma_fsab_subdid;
				fsabi_data   = {{1'b0, addr_q[0]}, ~{1'b0, addr_q[0]}};
				fsabo_credit = 1'b1; // one credit back per answer.
				credits++;
				void'(addr_q.pop_front());
				void'(due_q.pop_front());
			end else if ($urandom_range(0, 7) == 0) begin
				// traffic for some other device.
				fsabi_valid  = 1'b1;
				fsabi_did    = ($urandom_range(0, 1) == 1) ? dma_fsab_did : 4'h7;
				fsabi_subdid = (fsabi_did == dma_fsab_did) ? 4'h9 : dma_fsab_subdid;
				fsabi_data   = {$urandom, $urandom};
			end
		end
	end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic rst_b
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

	initial begin
		rst_b = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_b = 1'b1; // released away from the active edge.
	end

endmodule

// ==== logic/dma_read_controller.sv ====
`timescale 1ns/10ps

module dma_read_controller (
	input  logic                              clk,
	input  logic                              rst_b,
	output logic                              fsabo_valid,
	output fsab_pkg::fsab_req_e               fsabo_mode,
	output logic [fsab_pkg::fsab_did_w-1:0]   fsabo_did,
	output logic [fsab_pkg::fsab_did_w-1:0]   fsabo_subdid,
	output logic [fsab_pkg::fsab_addr_w-1:0]  fsabo_addr,
	output logic [fsab_pkg::fsab_len_w-1:0]   fsabo_len,
	output logic [fsab_pkg::fsab_data_w-1:0]  fsabo_data,
	output logic [fsab_pkg::fsab_mask_w-1:0]  fsabo_mask,
	input  logic                              fsabo_credit,
	input  logic                              fsabi_valid,
	input  logic [fsab_pkg::fsab_did_w-1:0]   fsabi_did,
	input  logic [fsab_pkg::fsab_did_w-1:0]   fsabi_subdid,
	input  logic [fsab_pkg::fsab_data_w-1:0]  fsabi_data,
	input  logic                              spamo_valid,
	input  logic                              spamo_r_nw,
	input  logic [spam_pkg::spam_did_w-1:0]   spamo_did,
	input  logic [spam_pkg::spam_addr_w-1:0]  spamo_addr,
	input  logic [spam_pkg::spam_data_w-1:0]  spamo_data,
	output logic                              spami_busy_b,
	output logic [spam_pkg::spam_data_w-1:0]  spami_data
);
	import fsab_pkg::*;

	// fetch engine to fifo.
	logic                   fifo_push;
	logic [fsab_data_w-1:0] fifo_wdata;
	logic [fifo_ptr_w:0]    fifo_count;

	// fifo to register port.
	logic                   fifo_pop;
	logic [fsab_data_w-1:0] fifo_rdata;
	logic                   fifo_empty;

	// configuration levels.
	logic [fsab_addr_w-1:0] cfg_start;
	logic [fsab_addr_w-1:0] cfg_len;
	logic                   cfg_auto;
	logic                   cfg_trigger;
	logic                   burst_start;

	dma_fetch_engine u_fetch (
		.clk          (clk),
		.rst_b        (rst_b),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data),
		.cfg_start    (cfg_start),
		.cfg_len      (cfg_len),
		.cfg_auto     (cfg_auto),
		.cfg_trigger  (cfg_trigger),
		.fifo_count   (fifo_count),
		.burst_start  (burst_start),
		.fifo_push    (fifo_push),
		.fifo_wdata   (fifo_wdata)
	);

	dma_read_fifo u_fifo (
		.clk        (clk),
		.rst_b      (rst_b),
		.fifo_push  (fifo_push),
		.fifo_wdata (fifo_wdata),
		.fifo_pop   (fifo_pop),
		.fifo_rdata (fifo_rdata),
		.fifo_count (fifo_count),
		.fifo_empty (fifo_empty)
	);

	dma_spam_port u_spam (
		.clk          (clk),
		.rst_b        (rst_b),
		.spamo_valid  (spamo_valid),
		.spamo_r_nw   (spamo_r_nw),
		.spamo_did    (spamo_did),
		.spamo_addr   (spamo_addr),
		.spamo_data   (spamo_data),
		.spami_busy_b (spami_busy_b),
		.spami_data   (spami_data),
		.fifo_rdata   (fifo_rdata),
		.fifo_empty   (fifo_empty),
		.fifo_pop     (fifo_pop),
		.burst_start  (burst_start),
		.cfg_start    (cfg_start),
		.cfg_len      (cfg_len),
		.cfg_auto     (cfg_auto),
		.cfg_trigger  (cfg_trigger)
	);

endmodule

// ==== logic/dma_spam_port.sv ====
`timescale 1ns/10ps

module dma_spam_port (
	input  logic                              clk,
	input  logic                              rst_b,
	input  logic                              spamo_valid,
	input  logic                              spamo_r_nw,
	input  logic [spam_pkg::spam_did_w-1:0]   spamo_did,
	input  logic [spam_pkg::spam_addr_w-1:0]  spamo_addr,
	input  logic [spam_pkg::spam_data_w-1:0]  spamo_data,
	output logic                              spami_busy_b,
	output logic [spam_pkg::spam_data_w-1:0]  spami_data,
	input  logic [fsab_pkg::fsab_data_w-1:0]  fifo_rdata,
	input  logic                              fifo_empty,
	output logic                              fifo_pop,
	input  logic                              burst_start,
	output logic [fsab_pkg::fsab_addr_w-1:0]  cfg_start,
	output logic [fsab_pkg::fsab_addr_w-1:0]  cfg_len,
	output logic                              cfg_auto,
	output logic                              cfg_trigger
);
	import spam_pkg::*;
	import fsab_pkg::*;

	logic      hit;
	logic      wr_hit;
	logic      rd_hit;
	spam_reg_e reg_sel;

	// device id and prefix both have to match.
	assign hit = spamo_valid && (spamo_did == dma_spam_did) &&
		((spamo_addr & dma_spam_mask) == (dma_spam_prefix & dma_spam_mask));
	assign wr_hit  = hit && !spamo_r_nw;
	assign rd_hit  = hit && spamo_r_nw;
	assign reg_sel = spam_reg_e'(spamo_addr[1:0]);

	// empty fifo means no response, host tries again.
	assign fifo_pop = rd_hit && !fifo_empty;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			cfg_start   <= '0;
			cfg_len     <= '0;
			cfg_auto    <= 1'b0;
			cfg_trigger <= 1'b0;
		end else begin
			// engine took the trigger.
			if (burst_start) begin
				cfg_trigger <= 1'b0;
			end
			if (wr_hit) begin
				case (reg_sel)
					reg_start: begin
						// start is kept word aligned.
						cfg_start <= {spamo_data[fsab_addr_w-1:3], 3'b000};
					end
					reg_len: begin
						cfg_len <= spamo_data[fsab_addr_w-1:0]; // in words.
					end
					reg_auto: begin
						cfg_auto <= spamo_data[0];
					end
					reg_trigger: begin
						cfg_trigger <= spamo_data[0]; // a new write beats the clear.
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			spami_busy_b <= 1'b0;
		end else begin
			spami_busy_b <= fifo_pop; // one cycle pulse per popped word.
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			spami_data <= fifo_rdata;
		end
	end

endmodule

// ==== logic/dma_read_fifo.sv ====
`timescale 1ns/10ps

module dma_read_fifo (
	input  logic                             clk,
	input  logic                             rst_b,
	input  logic                             fifo_push,
	input  logic [fsab_pkg::fsab_data_w-1:0] fifo_wdata,
	input  logic                             fifo_pop,
	output logic [fsab_pkg::fsab_data_w-1:0] fifo_rdata,
	output logic [fsab_pkg::fifo_ptr_w:0]    fifo_count,
	output logic                             fifo_empty
);
	import fsab_pkg::*;

	logic [fsab_data_w-1:0] mem [fifo_depth];
	logic [fifo_ptr_w-1:0]  wr_ptr;
	logic [fifo_ptr_w-1:0]  rd_ptr;

	always_ff @(posedge clk) begin
		if (fifo_push) begin
			mem[wr_ptr] <= fifo_wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (fifo_push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
			end
			if (fifo_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			fifo_count <= '0;
		end else begin
			case ({fifo_push, fifo_pop})
				2'b10: fifo_count <= fifo_count + 1'b1;
				2'b01: fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count; // same cycle push and pop.
			endcase
		end
	end

	// head word, valid whenever not empty.
	assign fifo_rdata = mem[rd_ptr];
	assign fifo_empty = (fifo_count == '0);

endmodule

// ==== logic/dma_fetch_engine.sv ====
`timescale 1ns/10ps

module dma_fetch_engine (
	input  logic                                 clk,
	input  logic                                 rst_b,
	output logic                                 fsabo_valid,
	output fsab_pkg::fsab_req_e                  fsabo_mode,
	output logic [fsab_pkg::fsab_did_w-1:0]      fsabo_did,
	output logic [fsab_pkg::fsab_did_w-1:0]      fsabo_subdid,
	output logic [fsab_pkg::fsab_addr_w-1:0]     fsabo_addr,
	output logic [fsab_pkg::fsab_len_w-1:0]      fsabo_len,
	output logic [fsab_pkg::fsab_data_w-1:0]     fsabo_data,
	output logic [fsab_pkg::fsab_mask_w-1:0]     fsabo_mask,
	input  logic                                 fsabo_credit,
	input  logic                                 fsabi_valid,
	input  logic [fsab_pkg::fsab_did_w-1:0]      fsabi_did,
	input  logic [fsab_pkg::fsab_did_w-1:0]      fsabi_subdid,
	input  logic [fsab_pkg::fsab_data_w-1:0]     fsabi_data,
	input  logic [fsab_pkg::fsab_addr_w-1:0]     cfg_start,
	input  logic [fsab_pkg::fsab_addr_w-1:0]     cfg_len,
	input  logic                                 cfg_auto,
	input  logic                                 cfg_trigger,
	input  logic [fsab_pkg::fifo_ptr_w:0]        fifo_count,
	output logic                                 burst_start,
	output logic                                 fifo_push,
	output logic [fsab_pkg::fsab_data_w-1:0]     fifo_wdata
);
	import fsab_pkg::*;

	typedef enum logic {
		burst_idle,
		burst_run
	} burst_state_e;

	burst_state_e              state;
	logic [fsab_addr_w-1:0]    next_addr;
	logic [fsab_addr_w-1:0]    words_left;
	logic [fsab_credits_w-1:0] credits;
	logic [fifo_ptr_w:0]       in_flight;
	logic                      resp_hit;
	logic                      resp_valid_q;
	logic [fsab_data_w-1:0]    resp_data_q;
	logic                      has_space;
	logic                      issue;
	logic                      want_start;

	// words already buffered plus words still coming back.
	assign has_space = ({1'b0, fifo_count} + {1'b0, in_flight}) <
		(fifo_ptr_w + 2)'(fifo_depth);
	assign issue = (state == burst_run) && (words_left != '0) && (credits != '0) && has_space;

	// idle, or every request of the burst is out.
	assign want_start = ((state == burst_idle) || (words_left == '0)) && !burst_start &&
		(cfg_trigger || (cfg_auto && (cfg_len != '0)));

	assign fsabo_valid  = issue;
	assign fsabo_mode   = fsab_read;
	assign fsabo_did    = dma_fsab_did;
	assign fsabo_subdid = dma_fsab_subdid;
	assign fsabo_addr   = next_addr;
	assign fsabo_len    = fsab_len_w'(1); // single word reads only.
	assign fsabo_data   = '0;
	assign fsabo_mask   = '0;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state       <= burst_idle;
			burst_start <= 1'b0;
			next_addr   <= '0;
			words_left  <= '0;
		end else begin
			burst_start <= want_start;
			if (burst_start) begin
				next_addr  <= cfg_start;
				words_left <= cfg_len;
				state      <= (cfg_len == '0) ? burst_idle : burst_run;
			end else if (issue) begin
				next_addr  <= next_addr + fsab_addr_w'(8);
				words_left <= words_left - 1'b1;
			end else if ((state == burst_run) && (words_left == '0) && !want_start) begin
				state <= burst_idle; // burst done, nothing queued.
			end
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits <= fsab_credits_w'(fsab_credits);
		end else begin
			case ({fsabo_credit, issue})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits; // none, or one in and one out.
			endcase
		end
	end

	// a read leaves flight when its word is pushed.
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			in_flight <= '0;
		end else begin
			case ({issue, fifo_push})
				2'b10: in_flight <= in_flight + 1'b1;
				2'b01: in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase
		end
	end

	assign resp_hit = fsabi_valid && (fsabi_did == dma_fsab_did) &&
		(fsabi_subdid == dma_fsab_subdid);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= resp_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (resp_hit) begin
			resp_data_q <= fsabi_data;
		end
	end

	assign fifo_push  = resp_valid_q;
	assign fifo_wdata = resp_data_q;

endmodule

// ==== logic/spam_pkg.sv ====
package spam_pkg;

	localparam int spam_addr_w = 24;
	localparam int spam_data_w = 64;
	localparam int spam_did_w  = 4;

	// device id of the controller.
	localparam logic [spam_did_w-1:0] dma_spam_did = 4'h3;

	// registers and data window share this prefix, low two bits pick the register.
	localparam logic [spam_addr_w-1:0] dma_spam_prefix = 24'h000010;
	localparam logic [spam_addr_w-1:0] dma_spam_mask   = 24'hfffffc;

	// register select for writes.
	typedef enum logic [1:0] {
		reg_start   = 2'd0,
		reg_len     = 2'd1,
		reg_auto    = 2'd2,
		reg_trigger = 2'd3
	} spam_reg_e;

endpackage

// ==== logic/fsab_pkg.sv ====
package fsab_pkg;

	// request side field widths.
	localparam int fsab_addr_w = 31; // byte address.
	localparam int fsab_data_w = 64;
	localparam int fsab_len_w  = 7;
	localparam int fsab_mask_w = 8;  // one bit per byte lane.
	localparam int fsab_did_w  = 4;

	// credits the controller owns out of reset.
	localparam int fsab_credits   = 4;
	localparam int fsab_credits_w = 3;

	// request opcodes.
	typedef enum logic [2:0] {
		fsab_read  = 3'b000,
		fsab_write = 3'b001
	} fsab_req_e;

	// ids the controller puts on its requests.
	// responses are matched against the same pair.
	localparam logic [fsab_did_w-1:0] dma_fsab_did    = 4'h2;
	localparam logic [fsab_did_w-1:0] dma_fsab_subdid = 4'h1;

	// read buffer between memory and register bus.
	localparam int fifo_depth = 16;
	localparam int fifo_ptr_w = 4; // log2 of depth.

endpackage
